// ==== sb_pkg.sv ====
`default_nettype none

package sb_pkg;

  // Buffer geometry
  localparam int sb_depth = 16;
  localparam int sb_index_bits = $clog2(sb_depth);
  // Whole doubleword address, bits 31 down to 3
  localparam int sb_tag_bits = 29;

  typedef logic [63:0] sb_dword_t;
  typedef logic [7:0] sb_strb_t;
  typedef logic [sb_index_bits-1:0] sb_index_t;

  // CPU side request where a zero strobe means a load
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    sb_dword_t   wdata;
    sb_strb_t    wstrb;
  } cpu_req_t;

  typedef struct packed {
    logic      ready;
    sb_dword_t rdata;
  } cpu_rsp_t;

  // Memory side request for a full doubleword
  typedef struct packed {
    logic        valid;
    logic        store;
    logic [31:0] addr;
    sb_dword_t   wdata;
  } mem_req_t;

  typedef struct packed {
    logic      ready;
    sb_dword_t rdata;
  } mem_rsp_t;

  // One line of the array
  typedef struct packed {
    logic                   valid;
    logic                   dirty;
    logic [sb_tag_bits-1:0] tag;
    sb_dword_t              data;
  } sb_entry_t;

  typedef struct packed {
    logic      en;
    sb_index_t index;
    sb_entry_t entry;
  } sb_ram_wr_t;

endpackage

`default_nettype wire

// ==== sb_entry_ram.sv ====
`default_nettype none

module sb_entry_ram
  import sb_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  sb_index_t  rd_index0,
  input  sb_index_t  rd_index1,
  output sb_entry_t  rd_entry0,
  output sb_entry_t  rd_entry1,
  input  sb_ram_wr_t wr0,
  input  sb_ram_wr_t wr1
);

  sb_entry_t entries [sb_depth];
  logic [sb_depth-1:0] valid_q;

  // Port 1 written last and wins on a shared index
  always_ff @(posedge clock) begin
    if (wr0.en) begin
      entries[wr0.index] <= wr0.entry;
    end
    if (wr1.en) begin
      entries[wr1.index] <= wr1.entry;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_q <= '0;
    end else begin
      if (wr0.en) begin
        valid_q[wr0.index] <= wr0.entry.valid;
      end
      if (wr1.en) begin
        valid_q[wr1.index] <= wr1.entry.valid;
      end
    end
  end

  // Reads see last cycle's contents with no bypass
  always_comb begin
    rd_entry0 = entries[rd_index0];
    rd_entry0.valid = valid_q[rd_index0];
    rd_entry1 = entries[rd_index1];
    rd_entry1.valid = valid_q[rd_index1];
  end

endmodule

`default_nettype wire

// ==== sb_index_lock.sv ====
`default_nettype none

module sb_index_lock
  import sb_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      claim0,
  input  logic      claim1,
  input  sb_index_t index0,
  input  sb_index_t index1,
  input  logic      release0,
  input  logic      release1,
  output logic      grant0,
  output logic      grant1
);

  logic      owned0;
  logic      owned1;
  sb_index_t owned_index0;
  sb_index_t owned_index1;

  // Blocked while the other port holds the index
  assign grant0 = claim0 && !(owned1 && (owned_index1 == index0));

  // Port 0 takes precedence on a same-cycle tie
  assign grant1 = claim1 && !(owned0 && (owned_index0 == index1)) &&
                  !(claim0 && (index0 == index1));

  always_ff @(posedge clock) begin
    if (!reset) begin
      owned0 <= 1'b0;
      owned1 <= 1'b0;
    end else begin
      if (grant0) begin
        owned0 <= 1'b1;
      end else if (release0) begin
        owned0 <= 1'b0;
      end
      if (grant1) begin
        owned1 <= 1'b1;
      end else if (release1) begin
        owned1 <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (grant0) begin
      owned_index0 <= index0;
    end
    if (grant1) begin
      owned_index1 <= index1;
    end
  end

endmodule

`default_nettype wire

// ==== sb_port_ctrl.sv ====
`default_nettype none

module sb_port_ctrl
  import sb_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  cpu_req_t   cpu_req,
  output cpu_rsp_t   cpu_rsp,
  output mem_req_t   mem_req,
  input  mem_rsp_t   mem_rsp,
  output logic       claim,
  output sb_index_t  claim_index,
  input  logic       grant,
  output logic       lock_release,
  output sb_index_t  rd_index,
  input  sb_entry_t  rd_entry,
  output sb_ram_wr_t wr
);

  typedef enum logic [2:0] {
    idle,
    lookup,
    writeback,
    refill,
    respond
  } state_t;

  state_t    state;
  state_t    state_next;
  cpu_req_t  req_q;
  sb_entry_t entry_q;
  sb_entry_t entry_next;
  sb_entry_t merged;
  sb_index_t req_index;
  logic      accept;
  logic      is_store;
  logic      hit;

  assign claim = (state == idle) && cpu_req.valid;
  assign claim_index = cpu_req.addr[sb_index_bits+2:3];
  assign rd_index = claim_index;
  assign accept = claim && grant;

  assign req_index = req_q.addr[sb_index_bits+2:3];
  assign is_store = |req_q.wstrb;
  assign hit = entry_q.valid && (entry_q.tag == req_q.addr[31:3]);

  // Lock is dropped at the edge that ends the response
  assign lock_release = (state == respond);

  always_comb begin
    cpu_rsp.ready = (state == respond);
    if ((state == respond) && !is_store) begin
      cpu_rsp.rdata = entry_q.data;
    end else begin
      cpu_rsp.rdata = '0;
    end
  end

  // Strobed bytes over the buffered doubleword
  always_comb begin
    merged = entry_q;
    merged.dirty = 1'b1;
    for (int i = 0; i < 8; i++) begin
      if (req_q.wstrb[i]) begin
        merged.data[8*i +: 8] = req_q.wdata[8*i +: 8];
      end
    end
  end

  always_comb begin
    state_next = state;
    entry_next = entry_q;
    mem_req = '0;
    wr = '0;
    case (state)
      idle: begin
        if (accept) begin
          entry_next = rd_entry;
          state_next = lookup;
        end
      end
      lookup: begin
        if (hit) begin
          if (is_store) begin
            wr.en = 1'b1;
            wr.index = req_index;
            wr.entry = merged;
          end
          state_next = respond;
        end else if (entry_q.valid && entry_q.dirty) begin
          state_next = writeback;
        end else begin
          state_next = refill;
        end
      end
      writeback: begin
        // Victim address rebuilt from its tag
        mem_req.valid = 1'b1;
        mem_req.store = 1'b1;
        mem_req.addr = {entry_q.tag, 3'b000};
        mem_req.wdata = entry_q.data;
        if (mem_rsp.ready) begin
          state_next = refill;
        end
      end
      refill: begin
        mem_req.valid = 1'b1;
        mem_req.addr = {req_q.addr[31:3], 3'b000};
        if (mem_rsp.ready) begin
          entry_next.valid = 1'b1;
          entry_next.dirty = 1'b0;
          entry_next.tag = req_q.addr[31:3];
          entry_next.data = mem_rsp.rdata;
          wr.en = 1'b1;
          wr.index = req_index;
          wr.entry = entry_next;
          state_next = lookup;
        end
      end
      respond: begin
        state_next = idle;
      end
      default: begin
        state_next = idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      req_q <= cpu_req;
    end
    entry_q <= entry_next;
  end

endmodule

`default_nettype wire

// ==== store_buffer.sv ====
`default_nettype none

module store_buffer
  import sb_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  cpu_req_t cpu0_req,
  input  cpu_req_t cpu1_req,
  output cpu_rsp_t cpu0_rsp,
  output cpu_rsp_t cpu1_rsp,
  output mem_req_t mem0_req,
  output mem_req_t mem1_req,
  input  mem_rsp_t mem0_rsp,
  input  mem_rsp_t mem1_rsp
);

  logic       claim0;
  logic       claim1;
  sb_index_t  claim_index0;
  sb_index_t  claim_index1;
  logic       grant0;
  logic       grant1;
  logic       release0;
  logic       release1;
  sb_index_t  rd_index0;
  sb_index_t  rd_index1;
  sb_entry_t  rd_entry0;
  sb_entry_t  rd_entry1;
  sb_ram_wr_t wr0;
  sb_ram_wr_t wr1;

  sb_port_ctrl port0 (
    .clock        (clock),
    .reset        (reset),
    .cpu_req      (cpu0_req),
    .cpu_rsp      (cpu0_rsp),
    .mem_req      (mem0_req),
    .mem_rsp      (mem0_rsp),
    .claim        (claim0),
    .claim_index  (claim_index0),
    .grant        (grant0),
    .lock_release (release0),
    .rd_index     (rd_index0),
    .rd_entry     (rd_entry0),
    .wr           (wr0)
  );

  sb_port_ctrl port1 (
    .clock        (clock),
    .reset        (reset),
    .cpu_req      (cpu1_req),
    .cpu_rsp      (cpu1_rsp),
    .mem_req      (mem1_req),
    .mem_rsp      (mem1_rsp),
    .claim        (claim1),
    .claim_index  (claim_index1),
    .grant        (grant1),
    .lock_release (release1),
    .rd_index     (rd_index1),
    .rd_entry     (rd_entry1),
    .wr           (wr1)
  );

  sb_index_lock lock (
    .clock    (clock),
    .reset    (reset),
    .claim0   (claim0),
    .claim1   (claim1),
    .index0   (claim_index0),
    .index1   (claim_index1),
    .release0 (release0),
    .release1 (release1),
    .grant0   (grant0),
    .grant1   (grant1)
  );

  sb_entry_ram ram (
    .clock     (clock),
    .reset     (reset),
    .rd_index0 (rd_index0),
    .rd_index1 (rd_index1),
    .rd_entry0 (rd_entry0),
    .rd_entry1 (rd_entry1),
    .wr0       (wr0),
    .wr1       (wr1)
  );

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
`default_nettype none

module tb_mem_model
  import sb_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  mem_req_t mem0_req,
  input  mem_req_t mem1_req,
  output mem_rsp_t mem0_rsp,
  output mem_rsp_t mem1_rsp
);

  timeunit 1ns;
  timeprecision 1ps;

  // Contents seen by the DUT, and the image built from completed stores
  sb_dword_t mem [logic [31:0]];
  sb_dword_t golden [logic [31:0]];

  // Doubleword each entry should hold after the finished operations
  logic [31:0] resident [sb_depth] = '{default: '1};
  // Address of the operation each port is running
  logic [31:0] op_addr [2] = '{default: '0};

  logic [31:0] lfsr_state = 32'hd1a0;
  int error_count = 0;
  int write_count [2] = '{0, 0};
  int read_count [2] = '{0, 0};
  logic busy [2] = '{1'b0, 1'b0};
  int wait_left [2] = '{0, 0};
  mem_rsp_t rsp [2] = '{default: '0};

  assign mem0_rsp = rsp[0];
  assign mem1_rsp = rsp[1];

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h80200003;
    end else begin
      return state >> 1;
    end
  endfunction

  // One LFSR step per delay bit
  function automatic int take_delay();
    int delay;
    delay = 0;
    for (int i = 0; i < 2; i++) begin
      delay = (delay << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
    return delay;
  endfunction

  // Untouched memory reads as its own address twice
  function automatic sb_dword_t fill_word(input logic [31:0] addr);
    return {addr, addr};
  endfunction

  function automatic sb_dword_t read_word(input logic [31:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return fill_word(addr);
  endfunction

  function automatic sb_dword_t golden_word(input logic [31:0] addr);
    if (golden.exists(addr)) begin
      return golden[addr];
    end
    return fill_word(addr);
  endfunction

  task automatic apply_store(input logic [31:0] addr, input sb_dword_t wdata,
                             input sb_strb_t strb);
    logic [31:0] base;
    sb_dword_t word;
    base = {addr[31:3], 3'b000};
    word = golden_word(base);
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) begin
        word[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    golden[base] = word;
  endtask

  task automatic open_access(input int p, input logic [31:0] addr);
    op_addr[p] = addr;
  endtask

  task automatic close_access(input logic [31:0] addr);
    resident[addr[sb_index_bits+2:3]] = {addr[31:3], 3'b000};
  endtask

  task automatic check_mem_write(input string name, input mem_req_t expected,
                                 input mem_req_t actual);
    if (actual !== expected) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  always @(negedge clock) begin
    mem_req_t req;
    mem_req_t expected;
    for (int p = 0; p < 2; p++) begin
      req = (p == 0) ? mem0_req : mem1_req;
      if (!reset) begin
        busy[p] = 1'b0;
        rsp[p] = '0;
      end else if (rsp[p].ready) begin
        // Taken at the edge just gone
        rsp[p] = '0;
        busy[p] = 1'b0;
      end else if (req.valid) begin
        if (!busy[p]) begin
          busy[p] = 1'b1;
          wait_left[p] = take_delay();
        end
        if (wait_left[p] == 0) begin
          rsp[p].ready = 1'b1;
          if (req.store) begin
            // The victim is whatever last used this operation's index
            expected = '0;
            expected.valid = 1'b1;
            expected.store = 1'b1;
            expected.addr = resident[op_addr[p][sb_index_bits+2:3]];
            expected.wdata = golden_word(expected.addr);
            check_mem_write((p == 0) ? "mem0_req" : "mem1_req", expected, req);
            mem[{req.addr[31:3], 3'b000}] = req.wdata;
            rsp[p].rdata = '0;
            write_count[p]++;
          end else begin
            rsp[p].rdata = read_word({req.addr[31:3], 3'b000});
            read_count[p]++;
          end
        end else begin
          wait_left[p]--;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_store_buffer.sv ====
`default_nettype none

module tb_store_buffer
  import sb_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // Path codes 0 unchecked, 1 hit, 2 clean miss, 3 dirty miss
  typedef struct packed {
    logic [1:0]  port;
    logic        kind;
    logic [31:0] addr;
    sb_dword_t   wdata;
    sb_strb_t    strb;
    sb_dword_t   expected;
    logic [1:0]  path;
    logic [15:0] line_no;
  } op_t;

  logic     clock = 1'b0;
  logic     reset;
  cpu_req_t cpu0_req;
  cpu_req_t cpu1_req;
  cpu_rsp_t cpu0_rsp;
  cpu_rsp_t cpu1_rsp;
  mem_req_t mem0_req;
  mem_req_t mem1_req;
  mem_rsp_t mem0_rsp;
  mem_rsp_t mem1_rsp;

  op_t ops0 [$];
  op_t ops1 [$];
  int  line_total = 0;
  logic loaded = 1'b0;
  logic file_ok = 1'b1;
  int  error_count = 0;
  int  tests_run = 0;
  int  tests_failed = 0;
  int  reached [2] = '{0, 0};

  always #10 clock = ~clock;

  store_buffer UUT (
    .clock    (clock),
    .reset    (reset),
    .cpu0_req (cpu0_req),
    .cpu1_req (cpu1_req),
    .cpu0_rsp (cpu0_rsp),
    .cpu1_rsp (cpu1_rsp),
    .mem0_req (mem0_req),
    .mem1_req (mem1_req),
    .mem0_rsp (mem0_rsp),
    .mem1_rsp (mem1_rsp)
  );

  tb_mem_model mem_model (
    .clock    (clock),
    .reset    (reset),
    .mem0_req (mem0_req),
    .mem1_req (mem1_req),
    .mem0_rsp (mem0_rsp),
    .mem1_rsp (mem1_rsp)
  );

  task automatic load_ops();
    int fd;
    int n;
    int port;
    int kind;
    int path;
    int line_no;
    string text;
    logic [31:0] addr;
    sb_dword_t wdata;
    sb_dword_t expected;
    sb_strb_t strb;
    op_t op;
    fd = $fopen("store_buffer_input.txt", "r");
    if (fd == 0) begin
      file_ok = 1'b0;
      return;
    end
    line_no = 0;
    while (!$feof(fd)) begin
      text = "";
      n = $fgets(text, fd);
      line_no++;
      if (n > 0 && text.len() > 0 && text[0] != "#") begin
        n = $sscanf(text, "%d %d %h %h %h %h %d",
                    port, kind, addr, wdata, strb, expected, path);
        if (n == 7) begin
          op = '{port: port[1:0], kind: kind[0], addr: addr, wdata: wdata, strb: strb,
                 expected: expected, path: path[1:0], line_no: line_no[15:0]};
          line_total++;
          // Port 2 is a sync point for both drivers
          if (port == 2 || port == 0) begin
            ops0.push_back(op);
          end
          if (port == 2 || port == 1) begin
            ops1.push_back(op);
          end
        end
      end
    end
    $fclose(fd);
  endtask

  function automatic cpu_rsp_t port_rsp(input int p);
    return (p == 0) ? cpu0_rsp : cpu1_rsp;
  endfunction

  task automatic drive_req(input int p, input cpu_req_t req);
    if (p == 0) begin
      cpu0_req = req;
    end else begin
      cpu1_req = req;
    end
  endtask

  task automatic check_rdata(input string name, input sb_dword_t expected,
                             input sb_dword_t actual);
    if (actual !== expected) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_path(input int p, input op_t op, input int waited,
                            input int writes, input int reads);
    case (op.path)
      2'd1: if (waited != 2 || writes != 0 || reads != 0) begin
        $display("Port %0d line %0d: hit should answer in 2 cycles without memory traffic,",
                 p, op.line_no);
        $display("  but took %0d cycles with %0d writes and %0d reads", waited, writes, reads);
        error_count++;
      end
      2'd2: if (writes != 0 || reads != 1) begin
        $display("Port %0d line %0d: clean miss should do one refill and no write-back,",
                 p, op.line_no);
        $display("  but did %0d writes and %0d reads", writes, reads);
        error_count++;
      end
      2'd3: if (writes != 1 || reads != 1) begin
        $display("Port %0d line %0d: dirty miss should do one write-back and one refill,",
                 p, op.line_no);
        $display("  but did %0d writes and %0d reads", writes, reads);
        error_count++;
      end
      default: begin
      end
    endcase
  endtask

  task automatic run_op(input int p, input op_t op);
    cpu_req_t req;
    cpu_rsp_t rsp;
    int waited;
    int writes;
    int reads;
    int errors_before;
    begin
      errors_before = error_count + mem_model.error_count;
      writes = mem_model.write_count[p];
      reads = mem_model.read_count[p];
      req.valid = 1'b1;
      req.addr = op.addr;
      req.wdata = op.wdata;
      req.wstrb = op.kind ? op.strb : '0;
      mem_model.open_access(p, op.addr);
      @(negedge clock);
      drive_req(p, req);
      waited = 0;
      rsp = '0;
      while (!rsp.ready) begin
        @(negedge clock);
        waited++;
        rsp = port_rsp(p);
      end
      check_rdata((p == 0) ? "cpu0_rsp.rdata" : "cpu1_rsp.rdata",
                  op.kind ? 64'h0 : op.expected, rsp.rdata);
      if (op.kind) begin
        mem_model.apply_store(op.addr, op.wdata, op.strb);
      end
      mem_model.close_access(op.addr);
      writes = mem_model.write_count[p] - writes;
      reads = mem_model.read_count[p] - reads;
      check_path(p, op, waited, writes, reads);
      tests_run++;
      if (error_count + mem_model.error_count == errors_before) begin
        $display("Test line %0d port %0d %s %h: ok", op.line_no, p,
                 op.kind ? "store" : "load", op.addr);
      end else begin
        tests_failed++;
        $display("Test line %0d port %0d %s %h: failed", op.line_no, p,
                 op.kind ? "store" : "load", op.addr);
      end
    end
  endtask

  task automatic sync_ports(input int p);
    reached[p]++;
    wait (reached[1-p] >= reached[p]);
  endtask

  task automatic run_port(input int p);
    op_t op;
    while ((p == 0) ? ops0.size() > 0 : ops1.size() > 0) begin
      op = (p == 0) ? ops0.pop_front() : ops1.pop_front();
      if (op.port == 2'd2) begin
        // Request withdrawn while the other port catches up
        @(negedge clock);
        drive_req(p, '0);
        sync_ports(p);
      end else begin
        run_op(p, op);
      end
    end
    @(negedge clock);
    drive_req(p, '0);
  endtask

  initial begin
    reset = 1'b0;
    cpu0_req = '0;
    cpu1_req = '0;
    load_ops();
    loaded = 1'b1;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    if (file_ok && line_total > 0) begin
      fork
        run_port(0);
        run_port(1);
      join
      repeat (4) @(negedge clock);
    end else begin
      $display("Could not read any operations from store_buffer_input.txt");
      error_count++;
    end
    $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed,
             error_count + mem_model.error_count);
    if (error_count + mem_model.error_count == 0 && tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Each line gets 20 cycles plus slack for reset and drain
  initial begin
    wait (loaded);
    #((line_total * 20 + 200) * 20);
    $display("Timeout: the tests did not finish within %0d cycles", line_total * 20 + 200);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== store_buffer_input.txt ====
# port kind(0 load, 1 store) addr wdata strb expected_load_data path
# path: 0 unchecked, 1 hit, 2 clean miss, 3 dirty miss; port 2 syncs both ports
0 0 00001000 0000000000000000 00 0000100000001000 2
0 0 00001000 0000000000000000 00 0000100000001000 1
0 1 00001008 1122334455667788 0f 0000000000000000 2
0 0 00001008 0000000000000000 00 0000100855667788 1
0 1 00001008 aabbccdd00000000 f0 0000000000000000 1
0 0 00001008 0000000000000000 00 aabbccdd55667788 1
0 0 00001088 0000000000000000 00 0000108800001088 3
0 0 00001008 0000000000000000 00 aabbccdd55667788 2
0 0 00001000 0000000000000000 00 0000100000001000 1
0 0 00002000 0000000000000000 00 0000200000002000 2
0 1 00003010 0102030405060708 5a 0000000000000000 2
0 0 00003010 0000000000000000 00 0002300405000710 1
2 0 00000000 0000000000000000 00 0000000000000000 0
0 1 00004018 0badc0de0badc0de ff 0000000000000000 2
1 1 00005020 1234567812345678 ff 0000000000000000 2
0 0 00004018 0000000000000000 00 0badc0de0badc0de 1
1 0 00005020 0000000000000000 00 1234567812345678 1
2 0 00000000 0000000000000000 00 0000000000000000 0
0 1 00006028 deadbeefcafef00d ff 0000000000000000 0
1 0 00007028 0000000000000000 00 0000702800007028 0
0 0 00006028 0000000000000000 00 deadbeefcafef00d 0
1 0 00007028 0000000000000000 00 0000702800007028 0
2 0 00000000 0000000000000000 00 0000000000000000 0
0 1 00008030 1111111122222222 ff 0000000000000000 2
1 1 00009038 ffffffffffffabcd 03 0000000000000000 2
0 0 00008130 0000000000000000 00 0000813000008130 3
1 0 00009138 0000000000000000 00 0000913800009138 3
0 0 00008030 0000000000000000 00 1111111122222222 2
1 0 00009038 0000000000000000 00 000090380000abcd 2
2 0 00000000 0000000000000000 00 0000000000000000 0
1 0 00001008 0000000000000000 00 aabbccdd55667788 1

// ==== store_buffer.f ====
sb_pkg.sv
sb_entry_ram.sv
sb_index_lock.sv
sb_port_ctrl.sv
store_buffer.sv
tb_mem_model.sv
tb_store_buffer.sv
